// ==== dv/fetch_cases.txt ====
# name start_pc(hex) count stall_pct invalidate wait_max expected_apb_transfers
# One case per line. The start PC is reached by redirect, except for a first case at the reset PC.
reset_run 100 8 0 0 2 8
reuse_hot 100 8 0 0 2 0
cold_far 400 16 0 0 3 16
stall_mix 800 20 30 0 4 20
reuse_stall 800 20 50 0 1 0
invalidate_rerun 800 20 0 1 2 20
redirect_hop 1000 8 20 0 0 8
alias_back 100 8 10 0 5 8
wide_wait 2000 6 0 0 7 6
reuse_tail 2004 4 25 0 3 0

// ==== dv/fetch_unit_asserts.sv ====
`timescale 1ns/10ps

module fetch_unit_asserts
    import fetch_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input refill_state_t state,
    input paddr_t        paddr,
    input logic          psel,
    input logic          penable,
    input logic          pready,
    input logic          refill_done,
    input logic          refill_req,
    input paddr_t        refill_addr
);

    // ~~~~~~~~~~~~~~~~~~~~
    // APB protocol
    // ~~~~~~~~~~~~~~~~~~~~

    // An access phase only ever follows a cycle with psel already high.
    penable_needs_psel: assert property (@(posedge clock) disable iff (reset)
        penable |-> psel && $past(psel))
        else $error("penable is high without psel or without a setup cycle before it");

    setup_one_cycle: assert property (@(posedge clock) disable iff (reset)
        psel && !penable |=> psel && penable && $stable(paddr))
        else $error("Setup phase was not followed by an access phase at the same address");

    hold_until_ready: assert property (@(posedge clock) disable iff (reset)
        psel && penable && !pready |=> psel && penable && $stable(paddr))
        else $error("Access phase changed before pready");

    // ~~~~~~~~~~~~~~~~~~~~
    // Refill requester
    // ~~~~~~~~~~~~~~~~~~~~

    // The word just refilled is a hit on the next cycle, so no new transfer
    // starts for the same address.
    one_transfer_per_miss: assert property (@(posedge clock) disable iff (reset)
        refill_done |=> !(state == refill_idle && refill_req && refill_addr == $past(paddr)))
        else $error("A second transfer was requested for the word just refilled");

endmodule

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/10ps

module fetch_unit_tb
    import fetch_pkg::*;
;

    localparam addr_t RESET_PC   = 64'h100;
    localparam int    MAX_CASES  = 32;

    logic   clock;
    logic   reset;
    logic   redirect;
    addr_t  redirect_pc;
    logic   stall;
    logic   invalidate;
    logic   out_valid;
    inst_t  out_inst;
    addr_t  out_pc;
    paddr_t paddr;
    logic   psel;
    logic   penable;
    logic   pready;
    inst_t  prdata;

    integer seed = 32'hf1fe_3131;

    string case_name  [MAX_CASES];
    addr_t case_start [MAX_CASES];
    int    case_count [MAX_CASES];
    int    case_stall [MAX_CASES];
    int    case_inv   [MAX_CASES];
    int    case_wait  [MAX_CASES];
    int    case_xfers [MAX_CASES];
    int    num_cases;
    int    limit_cycles = 0;

    int     value_errors = 0;
    int     other_errors = 0;
    int     wait_max     = 0;  // Wait state bound of the running case.
    int     wait_left    = 0;
    logic   give_ready;
    paddr_t range_lo     = '0;
    paddr_t range_hi     = '0;
    int     range_transfers = 0;

    fetch_unit #(
        .RESET_PC   (RESET_PC),
        .INDEX_BITS (6)
    ) fetch_unit_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .invalidate  (invalidate),
        .out_valid   (out_valid),
        .out_inst    (out_inst),
        .out_pc      (out_pc),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .prdata      (prdata)
    );

    bind refill_apb_master fetch_unit_asserts fetch_unit_asserts_i (
        .clock       (clock),
        .reset       (reset),
        .state       (state),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .refill_done (refill_done),
        .refill_req  (refill_req),
        .refill_addr (refill_addr)
    );

    always #4 clock = !clock;

    function automatic int draw_below(input int bound);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % bound;
    endfunction

    function automatic inst_t memory_word(input paddr_t addr);
        return addr ^ 32'hA5A5_0000;  // Every word is a function of its own address.
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // APB memory model
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin
        give_ready = 1'b0;
        if (!reset && psel && !penable) begin
            wait_left  = draw_below(wait_max + 1);
            give_ready = (wait_left == 0);
        end else if (!reset && psel && penable && !pready) begin
            if (wait_left <= 1) begin
                give_ready = 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
        #1;
        pready = give_ready;
        prdata = give_ready ? memory_word(paddr) : '0;
    end

    // Only transfers inside the running case's range are counted.
    always @(posedge clock) begin
        if (!reset && psel && penable && pready && paddr >= range_lo && paddr < range_hi) begin
            range_transfers = range_transfers + 1;
        end
        if (reset && out_valid === 1'b1) begin
            other_errors = other_errors + 1;
            $display("out_valid was high while reset was asserted");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_inst(input string test, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            value_errors = value_errors + 1;
            $display("FAILED %s: instruction expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic check_pc(input string test, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            value_errors = value_errors + 1;
            $display("FAILED %s: pc expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic check_count(input string test, input int expected, input int actual);
        if (actual != expected) begin
            value_errors = value_errors + 1;
            $display("FAILED %s: APB transfers expected %0d actual %0d", test, expected, actual);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    fields;
        string line;
        num_cases = 0;
        fd = $fopen("dv/fetch_cases.txt", "r");
        if (fd == 0) begin
            other_errors = other_errors + 1;
            $display("Could not open the case file dv/fetch_cases.txt");
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %d %d %d %d %d", case_name[num_cases],
                    case_start[num_cases], case_count[num_cases], case_stall[num_cases],
                    case_inv[num_cases], case_wait[num_cases], case_xfers[num_cases]);
                if (fields == 7) begin
                    num_cases = num_cases + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // One case
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic run_case(input int idx);
        addr_t expected_pc;
        int    got;
        int    quiet;
        @(posedge clock);
        #1;
        wait_max        = case_wait[idx];
        range_lo        = case_start[idx][31:0];
        range_hi        = range_lo + paddr_t'(4 * case_count[idx]);
        range_transfers = 0;
        if (!(idx == 0 && case_start[idx] == RESET_PC)) begin
            redirect    = 1'b1;  // Overrides the stall that is still held.
            redirect_pc = case_start[idx];
            invalidate  = (case_inv[idx] != 0);
            @(posedge clock);
            #1;
            redirect   = 1'b0;
            invalidate = 1'b0;
        end
        stall = (draw_below(100) < case_stall[idx]);
        got   = 0;
        while (got < case_count[idx]) begin
            @(posedge clock);
            if (out_valid && !stall) begin
                expected_pc = case_start[idx] + addr_t'(4 * got);
                check_pc(case_name[idx], expected_pc, out_pc);
                check_inst(case_name[idx], memory_word(expected_pc[31:0]), out_inst);
                got = got + 1;
            end
            #1;
            stall = (draw_below(100) < case_stall[idx]);
        end
        stall = 1'b1;
        quiet = 0;
        while (quiet < 4) begin  // Let a refill of the next address finish.
            @(posedge clock);
            quiet = psel ? 0 : quiet + 1;
        end
        check_count(case_name[idx], case_xfers[idx], range_transfers);
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int total_cycles;

        clock       = 1'b0;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b1;
        invalidate  = 1'b0;
        pready      = 1'b0;
        prdata      = '0;

        load_cases();
        if (num_cases == 0 && other_errors == 0) begin
            other_errors = other_errors + 1;
            $display("The case file holds no usable test case");
        end
        total_cycles = 200;
        for (int i = 0; i < num_cases; i++) begin
            total_cycles = total_cycles + case_count[i] * (case_wait[i] + 8) + 50;
        end
        limit_cycles = total_cycles;

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end

        $display("Closing count: %0d value errors, %0d other errors",
            value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Widths with a meaning
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [63:0] addr_t;   // Instruction address on the core side.
    typedef logic [31:0] inst_t;   // One instruction word.
    typedef logic [31:0] paddr_t;  // Address on the APB side.

    // ~~~~~~~~~~~~~~~~~~~~
    // Refill requester FSM
    // ~~~~~~~~~~~~~~~~~~~~

    // Idle waits for a request, setup is the APB setup phase and access
    // lasts until the slave raises pready.
    typedef enum logic [1:0] {
        refill_idle   = 2'd0,
        refill_setup  = 2'd1,
        refill_access = 2'd2
    } refill_state_t;

endpackage

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 64'h100
) (
    input  logic  clock,
    input  logic  reset,

    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  stall,

    input  logic  miss,
    input  inst_t hit_inst,

    output addr_t fetch_pc,

    output logic  out_valid,
    output inst_t out_inst,
    output addr_t out_pc
);

    addr_t pc_plus4;
    addr_t next_pc;
    logic  advance;
    logic  load_out;

    // ~~~~~~~~~~~~~~~~~~~~
    // Next PC
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        pc_plus4 = fetch_pc + 64'd4;
        next_pc  = redirect ? redirect_pc : pc_plus4;  // Redirect wins over the sequential step.

        // A redirect moves the PC even under stall or a pending miss.
        advance  = redirect || (!stall && !miss);

        // Only a real hit that is not thrown away reaches the outputs.
        load_out = !redirect && !stall && !miss;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
        end else if (advance) begin
            fetch_pc <= next_pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;  // The word fetched in this cycle belongs to the old path.
        end else if (!stall) begin
            out_valid <= !miss;
        end
    end

    // The word and its address move only together with a valid hit.
    always_ff @(posedge clock) begin
        if (load_out) begin
            out_inst <= hit_inst;
            out_pc   <= fetch_pc;
        end
    end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC   = 64'h100,
    parameter int    INDEX_BITS = 6
) (
    input  logic   clock,
    input  logic   reset,

    input  logic   redirect,
    input  addr_t  redirect_pc,
    input  logic   stall,
    input  logic   invalidate,
    output logic   out_valid,
    output inst_t  out_inst,
    output addr_t  out_pc,

    output paddr_t paddr,
    output logic   psel,
    output logic   penable,
    input  logic   pready,
    input  inst_t  prdata
);

    addr_t  fetch_pc;
    inst_t  hit_inst;
    logic   miss;
    logic   refill_req;
    paddr_t refill_addr;
    logic   refill_done;
    inst_t  refill_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .miss        (miss),
        .hit_inst    (hit_inst),
        .fetch_pc    (fetch_pc),
        .out_valid   (out_valid),
        .out_inst    (out_inst),
        .out_pc      (out_pc)
    );

    inst_cache #(
        .INDEX_BITS (INDEX_BITS)
    ) inst_cache_i (
        .clock       (clock),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .invalidate  (invalidate),
        .hit_inst    (hit_inst),
        .miss        (miss),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data)
    );

    refill_apb_master refill_apb_master_i (
        .clock       (clock),
        .reset       (reset),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .prdata      (prdata)
    );

endmodule

// ==== logic/inst_cache.sv ====
`timescale 1ns/10ps

module inst_cache
    import fetch_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic   clock,
    input  logic   reset,

    input  addr_t  fetch_pc,
    input  logic   invalidate,

    output inst_t  hit_inst,
    output logic   miss,

    output logic   refill_req,
    output paddr_t refill_addr,
    input  logic   refill_done,
    input  inst_t  refill_data
);

    localparam int ENTRIES  = 1 << INDEX_BITS;
    localparam int TAG_BITS = 64 - 2 - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~

    tag_t               tag_mem  [ENTRIES];
    inst_t              data_mem [ENTRIES];
    logic [ENTRIES-1:0] valid_bits;

    index_t lookup_index;
    tag_t   lookup_tag;
    logic   hit;

    logic   pending;   // A refill has been handed to the APB side.
    addr_t  pend_pc;   // Full address of the word being refilled.
    index_t refill_index;
    tag_t   refill_tag;
    logic   start_refill;

    // ~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        lookup_index = fetch_pc[INDEX_BITS+1:2];
        lookup_tag   = fetch_pc[63:INDEX_BITS+2];

        hit      = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
        miss     = !hit;
        hit_inst = data_mem[lookup_index];
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Refill request
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        start_refill = miss && !pending;

        // The request shows up in the miss cycle and then stays up from
        // the pending flag, even if the PC has moved on by redirect.
        refill_req  = pending || miss;
        refill_addr = pending ? pend_pc[31:0] : fetch_pc[31:0];

        refill_index = pend_pc[INDEX_BITS+1:2];
        refill_tag   = pend_pc[63:INDEX_BITS+2];
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (refill_done) begin
            pending <= 1'b0;
        end else if (start_refill) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start_refill) begin
            pend_pc <= fetch_pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Array updates
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (refill_done) begin
            tag_mem[refill_index]  <= refill_tag;
            data_mem[refill_index] <= refill_data;
        end
    end

    // Invalidate goes first so a refill landing on the same edge survives.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else begin
            if (invalidate) begin
                valid_bits <= '0;
            end
            if (refill_done) begin
                valid_bits[refill_index] <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/refill_apb_master.sv ====
`timescale 1ns/10ps

module refill_apb_master
    import fetch_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  logic   refill_req,
    input  paddr_t refill_addr,
    output logic   refill_done,
    output inst_t  refill_data,

    output paddr_t paddr,
    output logic   psel,
    output logic   penable,
    input  logic   pready,
    input  inst_t  prdata
);

    refill_state_t state;
    refill_state_t state_next;
    logic          accept;

    // ~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        accept     = (state == refill_idle) && refill_req;
        state_next = state;
        case (state)
            refill_idle: begin
                if (refill_req) begin
                    state_next = refill_setup;
                end
            end
            refill_setup: begin
                state_next = refill_access;  // Setup lasts exactly one cycle.
            end
            refill_access: begin
                if (pready) begin
                    state_next = refill_idle;
                end
            end
            default: begin
                state_next = refill_idle;
            end
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= refill_idle;
        end else begin
            state <= state_next;
        end
    end

    // Captured on the way into setup and held through the access phase.
    always_ff @(posedge clock) begin
        if (accept) begin
            paddr <= refill_addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus and cache side
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        psel        = (state != refill_idle);
        penable     = (state == refill_access);
        refill_done = (state == refill_access) && pready;  // One cycle, on the last access beat.
        refill_data = prdata;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fetch unit testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module fetch_unit_tb \
    -Mdir obj_dir \
    -f src.f

# The simulation may stop on an assertion, so its status is not trusted alone.
sim_output=$(./obj_dir/Vfetch_unit_tb 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "^Testbench passed$"; then
    exit 0
else
    echo "Simulation did not report a pass."
    exit 1
fi

// ==== src.f ====
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/inst_cache.sv
logic/refill_apb_master.sv
logic/fetch_unit.sv
dv/fetch_unit_asserts.sv
dv/fetch_unit_tb.sv
